//--- source/ql_bus_pkg.sv
/*
 * Shared definitions for the QL bus glue.
 * Memory map masks, clock enable steps for an 84 MHz clk_sys,
 * the reset stretch length and the speed and RAM configuration enums.
 * Modules refer to these by scoped name.
 */

package ql_bus_pkg;

	// Bus widths
	localparam int ADDR_W = 24;
	localparam int DATA_W = 16;

	// CPU bus speed select
	typedef enum logic [1:0]
	{
		speed_ql,		// Original 7.5 MHz bus
		speed_16,
		speed_24,
		speed_full
	} cpu_speed_t;

	// RAM fitted, also sets address wrap
	typedef enum logic [1:0]
	{
		ram_128k,
		ram_640k,
		ram_896k,
		ram_4096k		// Also turns on GoldCard spaces
	} ram_cfg_t;

	// ================================================================
	// Fractional bus steps, 84 MHz * step / 65536
	// ================================================================
	localparam logic [16:0] FRACT_BUS_QL   = 17'd11702;	// ~15 MHz tick rate
	localparam logic [16:0] FRACT_BUS_16   = 17'd24966;	// ~32 MHz
	localparam logic [16:0] FRACT_BUS_24   = 17'd37449;	// ~48 MHz
	localparam logic [16:0] FRACT_BUS_FULL = 17'd65536;	// Tick every cycle

	// Fixed dividers
	localparam logic [9:0] DIV_131K = 10'd640;	// Refresh and RTC, 131.25 kHz
	localparam logic [9:0] DIV_VID  = 10'd8;	// 10.5 MHz pixel rate

	// CPU reset length in ce_bus_p pulses
	localparam logic [11:0] RESET_TICKS = 12'd4095;

	// Address wrap per RAM size
	localparam logic [23:0] ADDR_MASK_128K = 24'h03FFFF;	// 256k space
	localparam logic [23:0] ADDR_MASK_1M   = 24'h0FFFFF;
	localparam logic [23:0] ADDR_MASK_8M   = 24'h7FFFFF;	// RAM plus ext I/O

	// GoldCard I/O page registers, low address byte
	localparam logic [7:0] GC_SHADOW_ON  = 8'h60;
	localparam logic [7:0] GC_SHADOW_OFF = 8'h64;

endpackage

//--- source/ql_clock_enables.sv
/*
 * Clock enables for the QL bus.
 * A phase accumulator makes the two CPU bus phase enables at the
 * selected speed. Two counters give the refresh/RTC and pixel enables.
 * All enables are single-cycle pulses on clk_sys.
 */

`timescale 1ns/1ps

module ql_clock_enables
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  ql_bus_pkg::cpu_speed_t cpu_speed,
	output logic                   ce_bus_p,
	output logic                   ce_bus_n,
	output logic                   ce_131k,
	output logic                   ce_vid
);

	logic [16:0] fract_bus;		// Step for current speed
	logic [16:0] acc_sum;		// Bit 16 is the tick
	logic [15:0] acc;
	logic        bus_pol;		// Which phase gets the next tick
	logic [9:0]  div_131k;
	logic [9:0]  div_vid;

	always_comb
	begin
		case (cpu_speed)
			ql_bus_pkg::speed_ql: fract_bus = ql_bus_pkg::FRACT_BUS_QL;
			ql_bus_pkg::speed_16: fract_bus = ql_bus_pkg::FRACT_BUS_16;
			ql_bus_pkg::speed_24: fract_bus = ql_bus_pkg::FRACT_BUS_24;
			default:              fract_bus = ql_bus_pkg::FRACT_BUS_FULL;
		endcase
	end

	assign acc_sum = {1'b0, acc} + fract_bus;

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			acc      <= '0;
			bus_pol  <= 1'b0;
			ce_bus_p <= 1'b0;
			ce_bus_n <= 1'b0;
			div_131k <= '0;
			div_vid  <= '0;
			ce_131k  <= 1'b0;
			ce_vid   <= 1'b0;
		end
		else
		begin
			// CPU bus phases, carry steered by polarity
			acc      <= acc_sum[15:0];
			bus_pol  <= bus_pol ^ acc_sum[16];
			ce_bus_p <= acc_sum[16] && !bus_pol;
			ce_bus_n <= acc_sum[16] && bus_pol;

			// Refresh and RTC
			if (div_131k == ql_bus_pkg::DIV_131K - 10'd1)
				div_131k <= '0;
			else
				div_131k <= div_131k + 10'd1;
			ce_131k <= (div_131k == '0);

			// Pixel enable
			if (div_vid == ql_bus_pkg::DIV_VID - 10'd1)
				div_vid <= '0;
			else
				div_vid <= div_vid + 10'd1;
			ce_vid <= (div_vid == '0);
		end
	end

	// The two CPU phases must never overlap
	a_bus_phase_excl : assert property (@(posedge clk_sys) disable iff (reset)
		!(ce_bus_p && ce_bus_n));

endmodule

//--- source/ql_reset_ctrl.sv
/*
 * CPU reset stretcher.
 * Any reset request reloads a counter that runs down on bus phase
 * enables; the CPU stays in reset until it reaches zero. The RAM
 * configuration is only taken while the CPU is held in reset.
 */

`timescale 1ns/1ps

module ql_reset_ctrl
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 reset_req,	// Button, menu, ROM load
	input  logic                 ce_bus_p,
	input  ql_bus_pkg::ram_cfg_t ram_cfg_sel,
	output logic                 cpu_reset,
	output ql_bus_pkg::ram_cfg_t ram_cfg
);

	logic [11:0] reset_cnt;

	always_ff @(posedge clk_sys)
	begin
		if (reset || reset_req)
			reset_cnt <= ql_bus_pkg::RESET_TICKS;
		else if (ce_bus_p && reset_cnt != '0)
			reset_cnt <= reset_cnt - 12'd1;	// Count bus cycles, not clocks
	end

	assign cpu_reset = (reset_cnt != '0);

	// Memory map fixed while the CPU runs
	always_ff @(posedge clk_sys)
	begin
		if (cpu_reset)
			ram_cfg <= ram_cfg_sel;
	end

endmodule

//--- source/ql_bus_decode.sv
/*
 * QL address decoder.
 * Wraps the CPU address by RAM size and decodes the QL and GoldCard
 * memory regions. Drives SDRAM and VRAM strobes and holds the
 * GoldCard ROM shadow flag and the ZX8301 mode register.
 * Region selects are address only; strobes need an active cycle.
 */

`timescale 1ns/1ps

module ql_bus_decode
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 cpu_reset,
	input  ql_bus_pkg::ram_cfg_t ram_cfg,
	input  logic [ql_bus_pkg::ADDR_W-1:1] cpu_addr,
	input  logic                 cpu_as,
	input  logic                 cpu_rw,
	input  logic                 cpu_uds,
	input  logic                 cpu_lds,
	input  logic [ql_bus_pkg::DATA_W-1:0] cpu_dout,
	output logic                 sel_io,
	output logic                 sel_ram,
	output logic                 sel_rom,
	output logic                 sel_os_rom,
	output logic                 sel_ext_rom,
	output logic                 sel_gc_boot_rom,
	output logic                 sel_gc_os_rom,
	output logic                 cpu_rd,
	output logic                 gc_en,
	output logic                 rom_shadow,
	output logic [ql_bus_pkg::ADDR_W-1:0] sdram_addr,
	output logic                 sdram_wr,
	output logic                 sdram_oe,
	output logic                 vram_wr,
	output logic [7:0]           mc_stat
);

	logic [ql_bus_pkg::ADDR_W-1:0] addr_mask;
	logic [ql_bus_pkg::ADDR_W-1:0] addr;	// Wrapped byte address
	logic cpu_wr;
	logic xram;				// Extended RAM for this config
	logic gc_io, gc_ram1, gc_ram2;
	logic shadow_rd, shadow_wr;
	logic mc_stat_wr;

	// ================================================================
	// Address wrap
	// ================================================================
	always_comb
	begin
		case (ram_cfg)
			ql_bus_pkg::ram_128k: addr_mask = ql_bus_pkg::ADDR_MASK_128K;
			ql_bus_pkg::ram_640k,
			ql_bus_pkg::ram_896k: addr_mask = ql_bus_pkg::ADDR_MASK_1M;
			default:              addr_mask = ql_bus_pkg::ADDR_MASK_8M;
		endcase
	end

	// A0 set only for a lower-byte-only access
	assign addr   = {cpu_addr, !cpu_uds && cpu_lds} & addr_mask;
	assign cpu_rd = cpu_as && cpu_rw && (cpu_uds || cpu_lds);
	assign cpu_wr = cpu_as && !cpu_rw && (cpu_uds || cpu_lds);
	assign gc_en  = (ram_cfg == ql_bus_pkg::ram_4096k);

	// ================================================================
	// Region decode
	// ================================================================
	assign sel_io      = addr[23:14] == 10'h006;	// $18000-$1BFFF
	assign sel_rom     = addr[23:16] == 8'h00;		// $0000-$FFFF
	assign sel_ext_rom = addr[23:14] == 10'h003;	// $C000-$FFFF
	assign sel_os_rom  = sel_rom && !sel_ext_rom;

	always_comb
	begin
		case (ram_cfg)
			// 512k extra at $40000-$BFFFF
			ql_bus_pkg::ram_640k: xram = addr[23:20] == 4'h0 && ^addr[19:18];
			// 768k extra at $40000-$FFFFF
			ql_bus_pkg::ram_896k: xram = addr[23:20] == 4'h0 && |addr[19:18];
			// Up to $3FFFFF
			ql_bus_pkg::ram_4096k: xram = addr[23:22] == 2'b00 && |addr[21:18];
			default: xram = 1'b0;	// Base RAM only
		endcase
	end

	// GoldCard extras
	assign gc_io   = gc_en && addr[23:8] == 16'h01C0;	// $1C000-$1C0FF
	assign gc_ram1 = gc_en && addr[23:15] == 9'h002;	// $10000-$17FFF
	assign gc_ram2 = gc_en && addr[23:14] == 10'h007 && !gc_io;
	assign sel_gc_boot_rom = gc_en && addr[23:16] == 8'h04;	// Boot ROM copy
	assign sel_gc_os_rom   = gc_en && addr[23:16] == 8'h40;	// Original QL ROM

	assign sel_ram = addr[23:17] == 7'h01 || xram || gc_ram1 || gc_ram2;

	// ================================================================
	// Strobes
	// ================================================================
	// Boot copies ROM into shadow RAM, then reads come from it
	assign shadow_rd = gc_en && cpu_rd && sel_os_rom && rom_shadow;
	assign shadow_wr = gc_en && cpu_wr && sel_os_rom && !rom_shadow;

	assign sdram_addr = {3'b000, addr[21:1]};	// Word address
	assign sdram_oe   = (cpu_rd && sel_ram) || shadow_rd;
	assign sdram_wr   = (cpu_wr && sel_ram) || shadow_wr;
	assign vram_wr    = cpu_wr && addr[23:16] == 8'h02;

	// Partial decode, matches $18063
	assign mc_stat_wr = sel_io && {addr[6:5], addr[1]} == 3'b111 && cpu_wr && cpu_lds;

	always_ff @(posedge clk_sys)
	begin
		if (reset || cpu_reset)
			rom_shadow <= 1'b0;
		else if (gc_io && cpu_wr && cpu_uds && !cpu_lds)
		begin
			if (addr[7:0] == ql_bus_pkg::GC_SHADOW_ON)
				rom_shadow <= 1'b1;
			else if (addr[7:0] == ql_bus_pkg::GC_SHADOW_OFF)
				rom_shadow <= 1'b0;
		end
	end

	// ZX8301 mode register
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			mc_stat <= 8'h00;
		else if (mc_stat_wr)
			mc_stat <= cpu_dout[7:0];
	end

	a_sdram_rw_excl : assert property (@(posedge clk_sys) disable iff (reset)
		!(sdram_wr && sdram_oe));

endmodule

//--- source/ql_read_mux.sv
/*
 * CPU read data and DTACK steering.
 * Picks the read word from I/O, ROM, GoldCard ROM or SDRAM using the
 * decoded selects only. RAM and shadow cycles wait for the SDRAM
 * acknowledge; everything else acknowledges at once.
 */

`timescale 1ns/1ps

module ql_read_mux
(
	input  logic clk_sys,
	input  logic reset,
	input  logic sel_io,
	input  logic sel_ram,
	input  logic sel_rom,
	input  logic sel_os_rom,
	input  logic sel_ext_rom,
	input  logic sel_gc_boot_rom,
	input  logic sel_gc_os_rom,
	input  logic cpu_rd,
	input  logic gc_en,
	input  logic rom_shadow,
	input  logic [ql_bus_pkg::DATA_W-1:0] rom_data,
	input  logic [ql_bus_pkg::DATA_W-1:0] gc_rom_data,
	input  logic [ql_bus_pkg::DATA_W-1:0] sdram_data,
	input  logic [ql_bus_pkg::DATA_W-1:0] io_data,
	input  logic sdram_dtack,
	output logic [ql_bus_pkg::DATA_W-1:0] cpu_din,
	output logic cpu_dtack
);

	logic shadow_cyc;

	always_comb
	begin
		if (sel_io)
			cpu_din = io_data;		// Always mapped
		else if (gc_en && !rom_shadow)
		begin
			// GoldCard boot
			if (sel_rom || sel_gc_boot_rom)
				cpu_din = gc_rom_data;
			else if (sel_gc_os_rom)
				cpu_din = rom_data;
			else if (sel_ram)
				cpu_din = sdram_data;
			else
				cpu_din = '1;
		end
		else if (gc_en)
		begin
			// Shadow RAM in place of OS ROM
			if (sel_os_rom)
				cpu_din = sdram_data;
			else if (sel_ext_rom || sel_gc_os_rom)
				cpu_din = rom_data;
			else if (sel_ram)
				cpu_din = sdram_data;
			else
				cpu_din = '1;
		end
		else if (sel_rom)
			cpu_din = rom_data;		// OS plus ext ROM
		else if (sel_ram)
			cpu_din = sdram_data;
		else
			cpu_din = '1;			// Unmapped
	end

	// Shadow read when on, shadow fill write when off
	assign shadow_cyc = gc_en && sel_os_rom && (rom_shadow == cpu_rd);
	assign cpu_dtack  = (sel_ram || shadow_cyc) ? sdram_dtack : 1'b1;

	// No read may stall once SDRAM has answered
	a_rd_dtack : assert property (@(posedge clk_sys) disable iff (reset)
		cpu_rd && sdram_dtack |-> cpu_dtack);

endmodule

//--- source/ql_bus_glue.sv
/*
 * QL bus glue top level.
 * Joins clock enables, reset stretcher, address decoder and read
 * steering. The CPU bus and device data come in on ports, and the
 * SDRAM, VRAM and I/O controls go out.
 */

`timescale 1ns/1ps

module ql_bus_glue
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   reset_req,
	input  ql_bus_pkg::cpu_speed_t cpu_speed,
	input  ql_bus_pkg::ram_cfg_t   ram_cfg_sel,
	input  logic [ql_bus_pkg::ADDR_W-1:1] cpu_addr,
	input  logic                   cpu_as,
	input  logic                   cpu_rw,
	input  logic                   cpu_uds,
	input  logic                   cpu_lds,
	input  logic [ql_bus_pkg::DATA_W-1:0] cpu_dout,
	input  logic [ql_bus_pkg::DATA_W-1:0] rom_data,
	input  logic [ql_bus_pkg::DATA_W-1:0] gc_rom_data,
	input  logic [ql_bus_pkg::DATA_W-1:0] sdram_data,
	input  logic [ql_bus_pkg::DATA_W-1:0] io_data,
	input  logic                   sdram_dtack,
	output logic                   ce_bus_p,
	output logic                   ce_bus_n,
	output logic                   ce_131k,
	output logic                   ce_vid,
	output logic                   cpu_reset,
	output logic [ql_bus_pkg::DATA_W-1:0] cpu_din,
	output logic                   cpu_dtack,
	output logic [ql_bus_pkg::ADDR_W-1:0] sdram_addr,
	output logic                   sdram_wr,
	output logic                   sdram_oe,
	output logic                   vram_wr,
	output logic [7:0]             mc_stat,
	output logic                   sel_io
);

	ql_bus_pkg::ram_cfg_t ram_cfg;
	logic sel_ram, sel_rom, sel_os_rom, sel_ext_rom;
	logic sel_gc_boot_rom, sel_gc_os_rom;
	logic cpu_rd, gc_en, rom_shadow;

	ql_clock_enables ql_clock_enables_inst
	(
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_speed (cpu_speed),
		.ce_bus_p  (ce_bus_p),
		.ce_bus_n  (ce_bus_n),
		.ce_131k   (ce_131k),
		.ce_vid    (ce_vid)
	);

	ql_reset_ctrl ql_reset_ctrl_inst
	(
		.clk_sys     (clk_sys),
		.reset       (reset),
		.reset_req   (reset_req),
		.ce_bus_p    (ce_bus_p),
		.ram_cfg_sel (ram_cfg_sel),
		.cpu_reset   (cpu_reset),
		.ram_cfg     (ram_cfg)
	);

	ql_bus_decode ql_bus_decode_inst
	(
		.clk_sys         (clk_sys),
		.reset           (reset),
		.cpu_reset       (cpu_reset),
		.ram_cfg         (ram_cfg),
		.cpu_addr        (cpu_addr),
		.cpu_as          (cpu_as),
		.cpu_rw          (cpu_rw),
		.cpu_uds         (cpu_uds),
		.cpu_lds         (cpu_lds),
		.cpu_dout        (cpu_dout),
		.sel_io          (sel_io),
		.sel_ram         (sel_ram),
		.sel_rom         (sel_rom),
		.sel_os_rom      (sel_os_rom),
		.sel_ext_rom     (sel_ext_rom),
		.sel_gc_boot_rom (sel_gc_boot_rom),
		.sel_gc_os_rom   (sel_gc_os_rom),
		.cpu_rd          (cpu_rd),
		.gc_en           (gc_en),
		.rom_shadow      (rom_shadow),
		.sdram_addr      (sdram_addr),
		.sdram_wr        (sdram_wr),
		.sdram_oe        (sdram_oe),
		.vram_wr         (vram_wr),
		.mc_stat         (mc_stat)
	);

	// Steering sees selects only, never the address
	ql_read_mux ql_read_mux_inst
	(
		.clk_sys         (clk_sys),
		.reset           (reset),
		.sel_io          (sel_io),
		.sel_ram         (sel_ram),
		.sel_rom         (sel_rom),
		.sel_os_rom      (sel_os_rom),
		.sel_ext_rom     (sel_ext_rom),
		.sel_gc_boot_rom (sel_gc_boot_rom),
		.sel_gc_os_rom   (sel_gc_os_rom),
		.cpu_rd          (cpu_rd),
		.gc_en           (gc_en),
		.rom_shadow      (rom_shadow),
		.rom_data        (rom_data),
		.gc_rom_data     (gc_rom_data),
		.sdram_data      (sdram_data),
		.io_data         (io_data),
		.sdram_dtack     (sdram_dtack),
		.cpu_din         (cpu_din),
		.cpu_dtack       (cpu_dtack)
	);

endmodule

//--- test/tb_clock_gen.sv
/*
 * Testbench clock and reset source.
 * Makes a 40 ns clk_sys and holds reset high for two rising edges,
 * then drops it on a falling edge.
 */

`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk_sys,
	output logic reset
);

	initial
	begin
		clk_sys = 1'b0;
		forever
			#20 clk_sys = !clk_sys;	// 40 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (2)
			@(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;		// Same edge as all other inputs
	end

endmodule

//--- test/tb_ql_bus_glue.sv
/*
 * Testbench for the QL bus glue.
 * Checks the clock enables, the CPU reset stretch, address wrap, the QL
 * and GoldCard read maps, DTACK, the shadow register and the video mode
 * register. Inputs change on falling edges, outputs are checked in the
 * low half of the clock.
 */

`timescale 1ns/1ps

module tb_ql_bus_glue;

	logic clk_sys;
	logic reset;
	logic reset_req;
	ql_bus_pkg::cpu_speed_t cpu_speed;
	ql_bus_pkg::ram_cfg_t   ram_cfg_sel;
	logic [ql_bus_pkg::ADDR_W-1:1] cpu_addr;
	logic cpu_as, cpu_rw, cpu_uds, cpu_lds;
	logic [ql_bus_pkg::DATA_W-1:0] cpu_dout;
	logic [ql_bus_pkg::DATA_W-1:0] rom_data, gc_rom_data, sdram_data, io_data;
	logic sdram_dtack;
	logic ce_bus_p, ce_bus_n, ce_131k, ce_vid;
	logic cpu_reset;
	logic [ql_bus_pkg::DATA_W-1:0] cpu_din;
	logic cpu_dtack;
	logic [ql_bus_pkg::ADDR_W-1:0] sdram_addr;
	logic sdram_wr, sdram_oe, vram_wr;
	logic [7:0] mc_stat;
	logic sel_io;

	integer seed;
	int errors;
	int gap;
	int count;
	int n;
	logic [15:0] wdata;

	tb_clock_gen tb_clock_gen_inst
	(
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	ql_bus_glue ql_bus_glue_inst
	(
		.clk_sys     (clk_sys),
		.reset       (reset),
		.reset_req   (reset_req),
		.cpu_speed   (cpu_speed),
		.ram_cfg_sel (ram_cfg_sel),
		.cpu_addr    (cpu_addr),
		.cpu_as      (cpu_as),
		.cpu_rw      (cpu_rw),
		.cpu_uds     (cpu_uds),
		.cpu_lds     (cpu_lds),
		.cpu_dout    (cpu_dout),
		.rom_data    (rom_data),
		.gc_rom_data (gc_rom_data),
		.sdram_data  (sdram_data),
		.io_data     (io_data),
		.sdram_dtack (sdram_dtack),
		.ce_bus_p    (ce_bus_p),
		.ce_bus_n    (ce_bus_n),
		.ce_131k     (ce_131k),
		.ce_vid      (ce_vid),
		.cpu_reset   (cpu_reset),
		.cpu_din     (cpu_din),
		.cpu_dtack   (cpu_dtack),
		.sdram_addr  (sdram_addr),
		.sdram_wr    (sdram_wr),
		.sdram_oe    (sdram_oe),
		.vram_wr     (vram_wr),
		.mc_stat     (mc_stat),
		.sel_io      (sel_io)
	);

	// ================================================================
	// Failure reporting
	// ================================================================
	task abort_run;
		$display("RESULT: FAIL");
		$fatal(1, "Stopped at the first failed check");
	endtask

	task report_mismatch(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("[FAIL] %s expected %0h actual %0h", test_name, expected, actual);
		abort_run();
	endtask

	task report_problem(input string what);
		errors++;
		$display("ERROR: %s", what);
		abort_run();
	endtask

	task check_equal(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
			report_mismatch(test_name, expected, actual);
	endtask

	// ================================================================
	// Bus phases alternate strictly at full speed
	// ================================================================
	a_full_p_then_n : assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_speed == ql_bus_pkg::speed_full && ce_bus_p) |=> ce_bus_n)
		else report_problem("ce_bus_n did not follow ce_bus_p at full speed");

	a_full_n_then_p : assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_speed == ql_bus_pkg::speed_full && ce_bus_n) |=> ce_bus_p)
		else report_problem("ce_bus_p did not follow ce_bus_n at full speed");

	// Mode register takes the low byte one edge after a write to $18063
	a_mc_stat_load : assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_as && !cpu_rw && cpu_lds && cpu_addr == 23'h00C031)
		|=> mc_stat == $past(cpu_dout[7:0]))
		else report_problem("mc_stat did not load the written byte");

	// ================================================================
	// Helpers
	// ================================================================
	function automatic logic enable_level(input string name);
		case (name)
			"ce_vid":   return ce_vid;
			"ce_131k":  return ce_131k;
			"ce_bus_p": return ce_bus_p;
			default:    return ce_bus_n;
		endcase
	endfunction

	// Leaves us on a falling edge with the enable high
	task automatic wait_enable(input string name, input int limit);
		int k;
		k = 0;
		@(negedge clk_sys);
		while (!enable_level(name) && k < limit)
		begin
			@(negedge clk_sys);
			k++;
		end
		if (!enable_level(name))
			report_problem({name, " never pulsed"});
	endtask

	task automatic measure_gap(input string name, output int cycles);
		wait_enable(name, 2000);
		cycles = 0;
		do
		begin
			@(negedge clk_sys);
			cycles++;
		end
		while (!enable_level(name) && cycles < 2000);
		if (!enable_level(name))
			report_problem({name, " stopped pulsing"});
	endtask

	// Reset request, new RAM config, then count the stretch
	task automatic apply_config(input ql_bus_pkg::ram_cfg_t cfg);
		int pulses;
		int k;
		@(negedge clk_sys);
		ram_cfg_sel = cfg;
		reset_req   = 1'b1;
		repeat (2)
			@(negedge clk_sys);
		reset_req = 1'b0;
		pulses = 0;
		k = 0;
		while (cpu_reset && k < 20000)
		begin
			if (ce_bus_p)
				pulses++;	// Used by the next rising edge
			@(negedge clk_sys);
			k++;
		end
		if (cpu_reset)
			report_problem("cpu_reset never dropped after a reset request");
		check_equal("reset stretch", ql_bus_pkg::RESET_TICKS, pulses);
	endtask

	// Starts a bus cycle with fresh device data, then settles
	task automatic start_cycle(input logic [23:0] byte_addr, input logic rw,
		input logic uds, input logic lds, input logic [15:0] data);
		@(negedge clk_sys);
		rom_data    = $random(seed);
		gc_rom_data = $random(seed);
		sdram_data  = $random(seed);
		io_data     = $random(seed);
		cpu_addr    = byte_addr[23:1];
		cpu_rw      = rw;
		cpu_uds     = uds;
		cpu_lds     = lds;
		cpu_dout    = data;
		cpu_as      = 1'b1;
		#10;
	endtask

	task end_cycle;
		@(negedge clk_sys);
		cpu_as      = 1'b0;
		cpu_uds     = 1'b0;
		cpu_lds     = 1'b0;
		cpu_rw      = 1'b1;
		sdram_dtack = 1'b0;
		#10;
	endtask

	// ================================================================
	// Stimulus
	// ================================================================
	initial
	begin
		seed        = 67254;
		errors      = 0;
		reset_req   = 1'b0;
		cpu_speed   = ql_bus_pkg::speed_full;
		ram_cfg_sel = ql_bus_pkg::ram_128k;
		cpu_addr    = '0;
		cpu_as      = 1'b0;
		cpu_rw      = 1'b1;
		cpu_uds     = 1'b0;
		cpu_lds     = 1'b0;
		cpu_dout    = '0;
		rom_data    = $random(seed);
		gc_rom_data = $random(seed);
		sdram_data  = $random(seed);
		io_data     = $random(seed);
		sdram_dtack = 1'b0;

		// First cycle after reset, everything quiet
		n = 0;
		do
		begin
			@(negedge clk_sys);
			#1;
			n++;
		end
		while (reset && n < 10);
		if (reset)
			report_problem("reset was never released");
		check_equal("enables after reset", 4'b0000, {ce_bus_p, ce_bus_n, ce_131k, ce_vid});

		// Divided enables
		measure_gap("ce_vid", gap);
		check_equal("ce_vid period", ql_bus_pkg::DIV_VID, gap);
		measure_gap("ce_131k", gap);
		check_equal("ce_131k period", ql_bus_pkg::DIV_131K, gap);
		measure_gap("ce_bus_p", gap);
		check_equal("ce_bus_p full period", 2, gap);
		measure_gap("ce_bus_n", gap);
		check_equal("ce_bus_n full period", 2, gap);

		// QL speed, half the ticks land on ce_bus_p
		@(negedge clk_sys);
		cpu_speed = ql_bus_pkg::speed_ql;
		count = 0;
		repeat (65536)
		begin
			@(negedge clk_sys);
			if (ce_bus_p)
				count++;
		end
		assert (count >= 5850 && count <= 5852)
		else
			report_mismatch("QL speed ce_bus_p count", 5851, count);
		@(negedge clk_sys);
		cpu_speed = ql_bus_pkg::speed_full;

		// ================================================================
		// 128k map
		// ================================================================
		apply_config(ql_bus_pkg::ram_128k);
		@(negedge clk_sys);
		ram_cfg_sel = ql_bus_pkg::ram_4096k;	// Ignored while CPU runs
		repeat (4)
			@(negedge clk_sys);

		start_cycle(24'h060000, 1'b1, 1'b1, 1'b1, 16'h0000);	// Wraps to $20000
		check_equal("128k wrap oe", 1, sdram_oe);
		check_equal("128k wrap addr", 24'h010000, sdram_addr);
		end_cycle();

		start_cycle(24'h000400, 1'b1, 1'b1, 1'b1, 16'h0000);
		check_equal("OS ROM read", rom_data, cpu_din);
		check_equal("OS ROM dtack", 1, cpu_dtack);
		end_cycle();
		start_cycle(24'h00C010, 1'b1, 1'b1, 1'b1, 16'h0000);
		check_equal("ext ROM read", rom_data, cpu_din);
		end_cycle();

		// RAM waits for SDRAM
		start_cycle(24'h028000, 1'b1, 1'b1, 1'b1, 16'h0000);
		check_equal("RAM read oe", 1, sdram_oe);
		check_equal("RAM read addr", 24'h014000, sdram_addr);
		check_equal("RAM dtack low", 0, cpu_dtack);
		@(negedge clk_sys);
		sdram_dtack = 1'b1;
		#10;
		check_equal("RAM read data", sdram_data, cpu_din);
		check_equal("RAM dtack high", 1, cpu_dtack);
		end_cycle();

		start_cycle(24'h018020, 1'b1, 1'b1, 1'b1, 16'h0000);
		check_equal("IO read data", io_data, cpu_din);
		check_equal("IO select", 1, sel_io);
		end_cycle();

		start_cycle(24'h01C100, 1'b1, 1'b1, 1'b1, 16'h0000);	// Hole above I/O
		check_equal("unmapped data", 16'hFFFF, cpu_din);
		check_equal("unmapped dtack", 1, cpu_dtack);
		end_cycle();

		// ================================================================
		// 4096k map with GoldCard
		// ================================================================
		apply_config(ql_bus_pkg::ram_4096k);
		start_cycle(24'h060000, 1'b1, 1'b1, 1'b1, 16'h0000);
		check_equal("4096k addr", 24'h030000, sdram_addr);
		check_equal("4096k oe", 1, sdram_oe);
		end_cycle();

		start_cycle(24'h000400, 1'b1, 1'b1, 1'b1, 16'h0000);
		check_equal("GC boot read", gc_rom_data, cpu_din);
		end_cycle();
		start_cycle(24'h000400, 1'b0, 1'b1, 1'b1, 16'h1234);	// Shadow fill
		check_equal("GC shadow fill wr", 1, sdram_wr);
		end_cycle();

		start_cycle(24'h01C060, 1'b0, 1'b1, 1'b0, 16'h0000);	// Shadow on
		end_cycle();
		start_cycle(24'h000400, 1'b1, 1'b1, 1'b1, 16'h0000);
		check_equal("shadow read data", sdram_data, cpu_din);
		check_equal("shadow read oe", 1, sdram_oe);
		check_equal("shadow dtack", 0, cpu_dtack);
		end_cycle();

		start_cycle(24'h01C064, 1'b0, 1'b1, 1'b0, 16'h0000);	// Shadow off
		end_cycle();
		start_cycle(24'h000400, 1'b1, 1'b1, 1'b1, 16'h0000);
		check_equal("shadow off read", gc_rom_data, cpu_din);
		end_cycle();

		// Mode register and VRAM
		wdata = $random(seed);
		start_cycle(24'h018063, 1'b0, 1'b0, 1'b1, wdata);
		end_cycle();
		check_equal("mc_stat write", wdata[7:0], mc_stat);

		start_cycle(24'h020100, 1'b0, 1'b1, 1'b1, 16'hA5A5);
		check_equal("VRAM write", 1, vram_wr);
		end_cycle();
		start_cycle(24'h030000, 1'b0, 1'b1, 1'b1, 16'h5A5A);	// Outside screen page
		check_equal("no VRAM write", 0, vram_wr);
		end_cycle();

		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- vlog.f
source/ql_bus_pkg.sv
source/ql_clock_enables.sv
source/ql_reset_ctrl.sv
source/ql_bus_decode.sv
source/ql_read_mux.sv
source/ql_bus_glue.sv
test/tb_clock_gen.sv
test/tb_ql_bus_glue.sv
